// ==== Makefile ====
SRCS := $(shell grep -v '^+' project.f)

.PHONY: run clean

run: obj_dir/VmmuTb
	@out="$$(./obj_dir/VmmuTb)"; echo "$$out"; \
	echo "$$out" | grep -q '^RESULT: PASS$$'

obj_dir/VmmuTb: project.f $(SRCS)
	verilator --binary --timing --assert --top-module mmuTb -f project.f

clean:
	rm -rf obj_dir

// ==== common/mmuPkg.sv ====
// mmu shared definitions for Sv32 translation
// widths, page table entry views, walk side and page kind
`default_nettype none

package mmuPkg;

   ////////////////////////////////////////////////////////////////////////////
   // address widths
   ////////////////////////////////////////////////////////////////////////////

   localparam int vaBits  = 32;   // virtual address
   localparam int paBits  = 34;   // Sv32 physical address
   localparam int ppnBits = 22;   // physical page number
   localparam int vpnBits = 20;   // virtual page number, vpn1 and vpn0

   ////////////////////////////////////////////////////////////////////////////
   // page table entry
   ////////////////////////////////////////////////////////////////////////////

   // one pte word, read as a pointer to the next table or as a leaf
   typedef union packed {
      struct packed {
         logic [ppnBits-1:0] ppn;    // full ppn, base of next level table
         logic [1:0]         rsw;    // reserved for software
         logic [7:0]         flags;  // not decoded on the pointer path
      } ptr;
      struct packed {
         logic [11:0] ppn1;          // megapage frame number
         logic [9:0]  ppn0;          // must be zero for a megapage
         logic [1:0]  rsw;
         logic        d;             // dirty
         logic        a;             // accessed
         logic        g;             // global
         logic        u;             // user
         logic        x;             // execute
         logic        w;             // write
         logic        r;             // read
         logic        v;             // valid
      } leaf;
   } sv32Pte_u;

   // which tlb a walk is serving
   typedef enum logic {instrSide, dataSide} walkSide_e;

   // kind of page held by a tlb entry, sets the number of offset bits
   typedef enum logic {kiloPage, megaPage} pageKind_e;

endpackage

`default_nettype wire

// ==== common/tlbFillIf.sv ====
// tlb fill port between one TLB and the page table walker
// carries the miss request out and the leaf entry back
`default_nettype none

interface tlbFillIf;
   import mmuPkg::*;

   // tlb to walker
   logic               miss;        // held while the request misses
   logic [vpnBits-1:0] missVpn;
   logic               missStore;   // the missing access is a store

   // walker to tlb, write is a single cycle pulse
   logic               write;
   logic [vpnBits-1:0] writeVpn;
   sv32Pte_u           writePte;
   pageKind_e          writeKind;

   modport tlb (output miss, missVpn, missStore,
                input  write, writeVpn, writePte, writeKind);

   modport walker (input  miss, missVpn, missStore,
                   output write, writeVpn, writePte, writeKind);

endinterface

`default_nettype wire

// ==== hdl/mmu.sv ====
// Sv32 mmu top level
// instruction and data TLBs sharing one page table walker
`default_nettype none

module mmu #(
   parameter int tlbEntries = 4                       // per tlb, power of two
) (
   input  logic                        clk,
   input  logic                        reset,
   input  logic [31:0]                 satp,

   // instruction side
   input  logic                        instrReq,
   input  logic [mmuPkg::vaBits-1:0]   instrVAdr,
   output logic [mmuPkg::paBits-1:0]   instrPAdr,
   output logic                        instrHit,

   // data side
   input  logic                        dataReq,
   input  logic [mmuPkg::vaBits-1:0]   dataVAdr,
   input  logic                        dataStore,
   output logic [mmuPkg::paBits-1:0]   dataPAdr,
   output logic                        dataHit,

   // Wishbone classic master, read only
   output logic                        wbCyc,
   output logic                        wbStb,
   output logic [mmuPkg::paBits-1:0]   wbAdr,
   input  logic [31:0]                 wbDatI,
   input  logic                        wbAck,

   // page faults, one cycle pulses
   output logic                        instrPageFault,
   output logic                        loadPageFault,
   output logic                        storePageFault
);

   tlbFillIf instrFill ();
   tlbFillIf dataFill ();

   tlb #(.tlbEntries(tlbEntries)) itlb (
      .clk   (clk),
      .reset (reset),
      .req   (instrReq),
      .vAdr  (instrVAdr),
      .store (1'b0),          // fetches never store
      .satp  (satp),
      .pAdr  (instrPAdr),
      .hit   (instrHit),
      .fill  (instrFill)
   );

   tlb #(.tlbEntries(tlbEntries)) dtlb (
      .clk   (clk),
      .reset (reset),
      .req   (dataReq),
      .vAdr  (dataVAdr),
      .store (dataStore),
      .satp  (satp),
      .pAdr  (dataPAdr),
      .hit   (dataHit),
      .fill  (dataFill)
   );

   pageTableWalker walker (
      .clk            (clk),
      .reset          (reset),
      .satp           (satp),
      .instrFill      (instrFill),
      .dataFill       (dataFill),
      .wbCyc          (wbCyc),
      .wbStb          (wbStb),
      .wbAdr          (wbAdr),
      .wbDatI         (wbDatI),
      .wbAck          (wbAck),
      .instrPageFault (instrPageFault),
      .loadPageFault  (loadPageFault),
      .storePageFault (storePageFault)
   );

endmodule

`default_nettype wire

// ==== hdl/tlb.sv ====
// fully associative TLB for Sv32 with combinational lookup
// entries are filled by the walker in round-robin order
`default_nettype none

module tlb #(
   parameter int tlbEntries = 4                     // power of two
) (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        req,         // translation request
   input  logic [mmuPkg::vaBits-1:0]   vAdr,
   input  logic                        store,
   input  logic [31:0]                 satp,
   output logic [mmuPkg::paBits-1:0]   pAdr,
   output logic                        hit,
   tlbFillIf.tlb                       fill
);
   import mmuPkg::*;

   localparam int idxBits = (tlbEntries > 1) ? $clog2(tlbEntries) : 1;

   logic [tlbEntries-1:0] valid;
   logic [vpnBits-1:0]    entryVpn  [tlbEntries];
   sv32Pte_u              entryPte  [tlbEntries];
   pageKind_e             entryKind [tlbEntries];
   logic [idxBits-1:0]    fillPtr;                  // next slot to replace

   logic [vpnBits-1:0]    vpn;
   logic                  bare;                     // satp mode clear
   logic                  matchAny;
   logic [idxBits-1:0]    matchIdx;
   sv32Pte_u              matchPte;
   logic                  dirtyBlock;               // store to a clean page
   logic                  translated;

   assign vpn  = vAdr[vaBits-1:12];
   assign bare = ~satp[31];

   ////////////////////////////////////////////////////////////////////////////
   // lookup
   ////////////////////////////////////////////////////////////////////////////

   // megapage entries compare vpn1 only
   always_comb begin
      matchAny = 1'b0;
      matchIdx = '0;
      for (int i = 0; i < tlbEntries; i++) begin
         if (valid[i] && (entryVpn[i][19:10] == vpn[19:10]) &&
             ((entryKind[i] == megaPage) || (entryVpn[i][9:0] == vpn[9:0]))) begin
            matchAny = 1'b1;
            matchIdx = idxBits'(i);
         end
      end
   end

   assign matchPte   = entryPte[matchIdx];
   assign dirtyBlock = store & ~matchPte.leaf.d;   // walker re-checks and faults
   assign translated = matchAny & ~dirtyBlock;

   always_comb begin
      if (bare)
         pAdr = {{(paBits-vaBits){1'b0}}, vAdr};   // zero extended va
      else if (entryKind[matchIdx] == megaPage)
         pAdr = {matchPte.leaf.ppn1, vAdr[21:0]};
      else
         pAdr = {matchPte.leaf.ppn1, matchPte.leaf.ppn0, vAdr[11:0]};
   end

   assign hit = req & (bare | translated);

   // miss never raised in bare mode
   assign fill.miss      = req & ~bare & ~translated;
   assign fill.missVpn   = vpn;
   assign fill.missStore = store;

   ////////////////////////////////////////////////////////////////////////////
   // fill
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         valid   <= '0;
         fillPtr <= '0;
      end else if (fill.write) begin
         valid[fillPtr] <= 1'b1;
         fillPtr <= (fillPtr == idxBits'(tlbEntries - 1)) ? '0 : fillPtr + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (fill.write) begin
         entryVpn[fillPtr]  <= fill.writeVpn;
         entryPte[fillPtr]  <= fill.writePte;
         entryKind[fillPtr] <= fill.writeKind;    // kilo or mega
      end
   end

endmodule

`default_nettype wire

// ==== pageTableWalker/pageTableWalker.sv ====
// Sv32 hardware page table walker, two levels, Wishbone classic master
// checks each pte, fills the missing TLB or raises the page fault
`default_nettype none

module pageTableWalker (
   input  logic                        clk,
   input  logic                        reset,
   input  logic [31:0]                 satp,
   tlbFillIf.walker                    instrFill,
   tlbFillIf.walker                    dataFill,
   output logic                        wbCyc,
   output logic                        wbStb,
   output logic [mmuPkg::paBits-1:0]   wbAdr,
   input  logic [31:0]                 wbDatI,
   input  logic                        wbAck,
   output logic                        instrPageFault,
   output logic                        loadPageFault,
   output logic                        storePageFault
);
   import mmuPkg::*;

   // walker states
   localparam logic [2:0] idle        = 3'd0;
   localparam logic [2:0] level1Bus   = 3'd1;   // read root table entry
   localparam logic [2:0] level1Check = 3'd2;
   localparam logic [2:0] level0Bus   = 3'd3;   // read second level entry
   localparam logic [2:0] level0Check = 3'd4;
   localparam logic [2:0] leaf        = 3'd5;   // tlb write pulse
   localparam logic [2:0] fault       = 3'd6;   // fault pulse

   logic [2:0]         state;
   logic [2:0]         nextState;
   logic               startWalk;

   walkSide_e          side;        // latched at walk start
   logic [vpnBits-1:0] vpn;
   logic               storeFlag;
   sv32Pte_u           pte;         // entry under check
   pageKind_e          kind;        // page kind of the leaf found

   logic               pteValid;
   logic               pteLeaf;
   logic               misaligned;
   logic               adFault;

   // data side wins when both tlbs miss
   assign startWalk = (state == idle) & (instrFill.miss | dataFill.miss);

   ////////////////////////////////////////////////////////////////////////////
   // entry checks
   ////////////////////////////////////////////////////////////////////////////

   assign pteValid   = pte.leaf.v & ~(pte.leaf.w & ~pte.leaf.r);
   assign pteLeaf    = pte.leaf.r | pte.leaf.w | pte.leaf.x;
   assign misaligned = |pte.leaf.ppn0;                          // megapage only
   assign adFault    = ~pte.leaf.a | (storeFlag & ~pte.leaf.d);

   ////////////////////////////////////////////////////////////////////////////
   // state machine
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      nextState = state;
      case (state)
         idle: begin
            if (startWalk)
               nextState = level1Bus;
         end
         level1Bus: begin
            if (wbAck)
               nextState = level1Check;   // entry captured this cycle
         end
         level1Check: begin
            if (pteValid && pteLeaf && !misaligned && !adFault)
               nextState = leaf;          // megapage
            else if (pteValid && !pteLeaf)
               nextState = level0Bus;     // pointer, go down one level
            else
               nextState = fault;
         end
         level0Bus: begin
            if (wbAck)
               nextState = level0Check;
         end
         level0Check: begin
            if (pteValid && pteLeaf && !adFault)
               nextState = leaf;          // kilopage
            else
               nextState = fault;         // pointer at the last level too
         end
         leaf:    nextState = idle;
         fault:   nextState = idle;
         default: nextState = idle;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset)
         state <= idle;
      else
         state <= nextState;
   end

   // walk context and captured entry
   always_ff @(posedge clk) begin
      if (startWalk) begin
         side      <= dataFill.miss ? dataSide : instrSide;
         vpn       <= dataFill.miss ? dataFill.missVpn : instrFill.missVpn;
         storeFlag <= dataFill.miss ? dataFill.missStore : instrFill.missStore;
      end
      if (wbCyc && wbAck)
         pte <= wbDatI;
      if ((state == level1Check) || (state == level0Check))
         kind <= (state == level1Check) ? megaPage : kiloPage;
   end

   ////////////////////////////////////////////////////////////////////////////
   // bus and outputs
   ////////////////////////////////////////////////////////////////////////////

   // cyc and stb held through the bus state, drop after ack
   assign wbCyc = (state == level1Bus) | (state == level0Bus);
   assign wbStb = wbCyc;

   always_comb begin
      if (state == level0Bus)
         wbAdr = {pte.ptr.ppn, vpn[9:0], 2'b00};           // next table from pointer
      else
         wbAdr = {satp[ppnBits-1:0], vpn[19:10], 2'b00};   // root table
   end

   assign instrFill.write     = (state == leaf) & (side == instrSide);
   assign instrFill.writeVpn  = vpn;
   assign instrFill.writePte  = pte;
   assign instrFill.writeKind = kind;

   assign dataFill.write      = (state == leaf) & (side == dataSide);
   assign dataFill.writeVpn   = vpn;
   assign dataFill.writePte   = pte;
   assign dataFill.writeKind  = kind;

   // fault output picked by latched side and access type
   assign instrPageFault = (state == fault) & (side == instrSide);
   assign loadPageFault  = (state == fault) & (side == dataSide) & ~storeFlag;
   assign storePageFault = (state == fault) & (side == dataSide) & storeFlag;

endmodule

`default_nettype wire

// ==== project.f ====
common/mmuPkg.sv
common/tlbFillIf.sv
hdl/tlb.sv
pageTableWalker/pageTableWalker.sv
hdl/mmu.sv
sim/pageTableMem.sv
sim/walker_chk.sv
sim/mmuTb.sv

// ==== sim/mmuTb.sv ====
// testbench for the Sv32 mmu
// page tables in a Wishbone memory model and a stimulus table applied row by row
`default_nettype none

module mmuTb;
   import mmuPkg::*;

   localparam logic [31:0] satpPaged = 32'h8000_0001;   // mode set with the root table at ppn 1
   localparam logic [21:0] level0Table = 22'h2;         // target of the only pointer entry

   // expected outcome of a row
   localparam logic [1:0] translated = 2'd0;
   localparam logic [1:0] instrFault = 2'd1;
   localparam logic [1:0] loadFault  = 2'd2;
   localparam logic [1:0] storeFault = 2'd3;

   // pte flags
   localparam logic [7:0] fV = 8'h01, fR = 8'h02, fW = 8'h04, fX = 8'h08;
   localparam logic [7:0] fA = 8'h40, fD = 8'h80;

   typedef struct packed {
      walkSide_e         side;
      logic              bare;      // satp mode clear
      logic [31:0]       va;
      logic              store;
      logic [1:0]        outcome;
      logic [paBits-1:0] pa;
      logic              bus;       // walk expected on the bus
   } testRow_t;

   logic clk, reset;
   logic [31:0] satp;
   logic instrReq, instrHit, dataReq, dataStore, dataHit;
   logic [31:0] instrVAdr, dataVAdr;
   logic [paBits-1:0] instrPAdr, dataPAdr, wbAdr;
   logic wbCyc, wbStb, wbAck;
   logic [31:0] wbDatI;
   logic instrPageFault, loadPageFault, storePageFault;

   testRow_t rows [$];
   int       passCount;
   int       failCount;

   mmu #(.tlbEntries(4)) uut (.*);

   pageTableMem ptMem (
      .clk   (clk),
      .reset (reset),
      .wbCyc (wbCyc),
      .wbStb (wbStb),
      .wbAdr (wbAdr),
      .wbDat (wbDatI),
      .wbAck (wbAck)
   );

   bind pageTableWalker walkerChk chk (
      .clk            (clk),
      .reset          (reset),
      .wbCyc          (wbCyc),
      .wbStb          (wbStb),
      .wbAdr          (wbAdr),
      .wbAck          (wbAck),
      .instrPageFault (instrPageFault),
      .loadPageFault  (loadPageFault),
      .storePageFault (storePageFault)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // page tables and stimulus table
   ////////////////////////////////////////////////////////////////////////////

   // entry address is the table base plus index times 4
   function automatic logic [paBits-1:0] pteAdr(input logic [21:0] tablePpn,
                                                input logic [9:0] index);
      return {tablePpn, index, 2'b00};
   endfunction

   task automatic writePte(input logic [paBits-1:0] adr, input logic [21:0] ppn,
                           input logic [7:0] flags);
      ptMem.mem[adr[13:2]] = {ppn, 2'b00, flags};
   endtask

   function automatic testRow_t makeRow(input walkSide_e side, input logic bare,
                                        input logic [31:0] va, input logic store,
                                        input logic [1:0] outcome,
                                        input logic [paBits-1:0] pa, input logic bus);
      return '{side, bare, va, store, outcome, pa, bus};
   endfunction

   task automatic loadTables();
      writePte(pteAdr(22'h1, 10'h001), level0Table, fV);               // pointer to ppn 2
      writePte(pteAdr(22'h1, 10'h002), 22'h2AC00, fV | fR | fX | fA);  // megapage at ppn1 0xab
      writePte(pteAdr(22'h1, 10'h003), 22'h15401, fV | fR | fA);       // ppn0 nonzero
      writePte(pteAdr(22'h1, 10'h004), 22'h00300, fV | fW | fA);       // w without r
      writePte(pteAdr(level0Table, 10'h003), 22'h12345, fV | fR | fW | fA | fD);
      writePte(pteAdr(level0Table, 10'h005), 22'h00777, fV | fR | fW | fD);  // a clear
      writePte(pteAdr(level0Table, 10'h006), 22'h00888, fV | fR | fW | fA);  // d clear
   endtask

   task automatic buildRows();
      rows.push_back(makeRow(dataSide,  0, 32'h0040_3123, 0, translated, 34'h0_1234_5123, 1));
      rows.push_back(makeRow(instrSide, 0, 32'h0080_2ABC, 0, translated, 34'h0_2AC0_2ABC, 1));
      rows.push_back(makeRow(dataSide,  0, 32'h0040_3FFC, 0, translated, 34'h0_1234_5FFC, 0));
      rows.push_back(makeRow(instrSide, 0, 32'h0080_2FF0, 0, translated, 34'h0_2AC0_2FF0, 0));
      rows.push_back(makeRow(dataSide,  0, 32'h0040_3010, 1, translated, 34'h0_1234_5010, 0));
      rows.push_back(makeRow(dataSide,  0, 32'h00C0_0010, 0, loadFault,  34'h0, 1));
      rows.push_back(makeRow(instrSide, 0, 32'h0100_0000, 0, instrFault, 34'h0, 1));
      rows.push_back(makeRow(dataSide,  0, 32'h0040_5000, 0, loadFault,  34'h0, 1));
      rows.push_back(makeRow(dataSide,  0, 32'h0040_6040, 1, storeFault, 34'h0, 1));
      rows.push_back(makeRow(dataSide,  0, 32'h0040_6040, 0, translated, 34'h0_0088_8040, 1));
      rows.push_back(makeRow(dataSide,  0, 32'h0040_6044, 1, storeFault, 34'h0, 1));
      rows.push_back(makeRow(dataSide,  1, 32'hFEDC_BA98, 0, translated, 34'h0_FEDC_BA98, 0));
      rows.push_back(makeRow(instrSide, 1, 32'h8000_0004, 0, translated, 34'h0_8000_0004, 0));
      rows.push_back(makeRow(dataSide,  0, 32'h0040_3123, 0, translated, 34'h0_1234_5123, 0));
   endtask

   function automatic string outcomeName(input logic [1:0] outcome);
      case (outcome)
         translated: return "translation";
         instrFault: return "instruction page fault";
         loadFault:  return "load page fault";
         default:    return "store page fault";
      endcase
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // one row with the request held until hit or fault
   ////////////////////////////////////////////////////////////////////////////

   task automatic runRow(input testRow_t r, input int idx);
      logic              done;
      logic              sawBus;
      logic [1:0]        got;
      logic [paBits-1:0] gotPa;
      logic [paBits-1:0] rootAdr;
      logic [paBits-1:0] nextAdr;
      int                errors;
      done    = 1'b0;
      sawBus  = 1'b0;
      got     = translated;
      gotPa   = '0;
      rootAdr = pteAdr(satpPaged[21:0], r.va[31:22]);   // level 1 entry
      nextAdr = pteAdr(level0Table, r.va[21:12]);       // level 0 entry below the pointer
      errors  = 0;
      @(posedge clk);
      satp      <= r.bare ? 32'h0 : satpPaged;
      instrReq  <= (r.side == instrSide);
      instrVAdr <= r.va;
      dataReq   <= (r.side == dataSide);
      dataVAdr  <= r.va;
      dataStore <= r.store;
      while (!done) begin
         @(negedge clk);                       // outputs settled mid cycle
         sawBus = sawBus | wbCyc;
         if (wbStb != wbCyc) begin
            $display("** Error at time %0t: row %0d wbStb %0b with wbCyc %0b", $time, idx,
                     wbStb, wbCyc);
            errors++;
         end
         if (wbCyc && (wbAdr != rootAdr) && (wbAdr != nextAdr)) begin
            $display("** Error at time %0t: row %0d wbAdr %h, expected %h or %h", $time,
                     idx, wbAdr, rootAdr, nextAdr);
            errors++;
         end
         gotPa  = (r.side == instrSide) ? instrPAdr : dataPAdr;
         done   = 1'b1;
         if ((r.side == instrSide) ? instrHit : dataHit)
            got = translated;
         else if (instrPageFault)
            got = instrFault;
         else if (loadPageFault)
            got = loadFault;
         else if (storePageFault)
            got = storeFault;
         else
            done = 1'b0;
      end
      @(posedge clk);
      instrReq  <= 1'b0;                       // drop before the walker restarts
      dataReq   <= 1'b0;
      dataStore <= 1'b0;
      if (r.outcome == translated && got != translated) begin
         $display("row %0d at time %0t: no hit, a %s was raised instead", idx, $time,
                  outcomeName(got));
         errors++;
      end else if (r.outcome != translated && got == translated) begin
         $display("row %0d at time %0t: access translated, a %s was expected", idx, $time,
                  outcomeName(r.outcome));
         errors++;
      end else if (got != r.outcome) begin
         $display("row %0d at time %0t: a %s was raised where a %s was expected", idx,
                  $time, outcomeName(got), outcomeName(r.outcome));
         errors++;
      end else if (got == translated && gotPa != r.pa) begin
         $display("** Error at time %0t: row %0d PA %h, expected %h", $time, idx, gotPa, r.pa);
         errors++;
      end
      if (sawBus != r.bus) begin
         $display("** Error at time %0t: row %0d bus cycle seen %0b, expected %0b", $time,
                  idx, sawBus, r.bus);
         errors++;
      end
      if (errors == 0) begin
         passCount++;
         $display("row %0d va %h: %s as expected", idx, r.va, outcomeName(got));
      end else begin
         failCount++;
         $display("row %0d va %h: failed", idx, r.va);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // main sequence and watchdog
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      reset     <= 1'b1;
      satp      <= '0;
      instrReq  <= 1'b0;
      instrVAdr <= '0;
      dataReq   <= 1'b0;
      dataVAdr  <= '0;
      dataStore <= 1'b0;
      passCount = 0;
      failCount = 0;
      buildRows();
      loadTables();
      repeat (8) @(posedge clk);
      reset <= 1'b0;
      for (int i = 0; i < rows.size(); i++)
         runRow(rows[i], i);
      repeat (2) @(posedge clk);
      $display("rows %0d, passed %0d, failed %0d", rows.size(), passCount, failCount);
      if (failCount == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

   // 60 cycles per row after reset
   initial begin
      int limit;
      @(posedge clk);
      limit = 8 + rows.size() * 60;
      repeat (limit) @(posedge clk);
      $display("watchdog: run still busy after %0d cycles, a request got no answer", limit);
      $display("RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// ==== sim/pageTableMem.sv ====
// Wishbone classic slave memory holding the Sv32 page tables
// read only, 0 to 3 random wait states per access
`default_nettype none

module pageTableMem (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      wbCyc,
   input  logic                      wbStb,
   input  logic [mmuPkg::paBits-1:0] wbAdr,
   output logic [31:0]               wbDat,
   output logic                      wbAck
);

   logic [31:0] mem [4096];   // 16 KiB, word index from address bits 13 to 2
   int          waitLeft;     // wait states still to insert
   logic        started;      // wait count drawn for the current cycle

   initial begin
      void'($urandom(32'ha5ca_2a01));
      wbAck   <= 1'b0;
      wbDat   <= '0;
      waitLeft = 0;
      started  = 1'b0;
      forever begin
         @(posedge clk);
         if (reset || wbAck || !(wbCyc && wbStb)) begin
            wbAck  <= 1'b0;                 // ack lasts one cycle
            started = 1'b0;
         end else begin
            if (!started) begin
               waitLeft = int'($urandom % 4);
               started  = 1'b1;
            end
            if (waitLeft == 0) begin
               wbAck <= 1'b1;
               wbDat <= mem[wbAdr[13:2]];
            end else begin
               waitLeft = waitLeft - 1;
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== sim/walker_chk.sv ====
// assertions on the walker's Wishbone port and fault pulses
`default_nettype none

module walkerChk (
   input logic                      clk,
   input logic                      reset,
   input logic                      wbCyc,
   input logic                      wbStb,
   input logic [mmuPkg::paBits-1:0] wbAdr,
   input logic                      wbAck,
   input logic                      instrPageFault,
   input logic                      loadPageFault,
   input logic                      storePageFault
);

   stbInCyc: assert property (@(posedge clk) disable iff (reset) wbStb |-> wbCyc)
      else $error("wbStb high outside a bus cycle");

   // address held until the slave acks
   adrStable: assert property (@(posedge clk) disable iff (reset)
      (wbStb && !wbAck) |=> $stable(wbAdr))
      else $error("wbAdr changed while waiting for ack");

   oneFault: assert property (@(posedge clk) disable iff (reset)
      $onehot0({instrPageFault, loadPageFault, storePageFault}))
      else $error("more than one page fault output high");

   noFaultInCyc: assert property (@(posedge clk) disable iff (reset)
      wbCyc |-> !(instrPageFault || loadPageFault || storePageFault))
      else $error("page fault raised during a bus cycle");

endmodule

`default_nettype wire
